// File: Makefile
# Verilator build and run for the Mandelbrot iteration engine

VERILATOR  ?= verilator
TOP        ?= mandel_engine_tb
RTL_TOP    ?= mandel_engine
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall -Wno-fatal

SOURCES     := $(shell grep -v '^+' $(FILELIST))
RTL_SOURCES := $(filter hw/%,$(SOURCES))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TB PASSED" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SOURCES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/mandel_engine_tb.sv
/* Self-checking testbench for the Mandelbrot iteration engine. Runs directed and
   random points under random back-pressure and checks result values and latency. */

`timescale 1ns/100ps
`default_nettype none

module mandel_engine_tb;

	localparam int CLK_PERIOD   = 40;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_RANDOM   = 200;
	localparam int NUM_TASKS    = NUM_RANDOM + 3;

	logic                         clk;
	logic                         reset;
	logic [mandel_pkg::VEC_W-1:0] snk_data;
	logic                         snk_valid;
	logic                         snk_ready;
	mandel_pkg::iters_t           src_data;
	logic                         src_valid;
	logic                         src_ready;

	// task list, filled before reset is released
	logic [mandel_pkg::VEC_W-1:0] task_vec [NUM_TASKS];
	bit                           tasks_ready = 1'b0;
	longint unsigned              watchdog_ns = 0;

	// accepted tasks waiting for their result
	mandel_pkg::iters_t expected_q[$];
	int unsigned        accept_cycle_q[$];

	int unsigned cycle_count = 0;
	int unsigned results_seen = 0;
	int unsigned mismatch_count = 0;
	int unsigned failure_count = 0;

	logic               src_valid_prev = 1'b0;
	logic               src_ready_prev = 1'b0;
	mandel_pkg::iters_t src_data_prev = '0;

	mandel_engine mandel_engine_inst (
		.clk       (clk),
		.reset     (reset),
		.snk_data  (snk_data),
		.snk_valid (snk_valid),
		.snk_ready (snk_ready),
		.src_data  (src_data),
		.src_valid (src_valid),
		.src_ready (src_ready)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// count for c = cr + i*ci, iterating z <- z^2 + c from z = 0
	function automatic mandel_pkg::iters_t expected_count(
		input mandel_pkg::coord_t cr,
		input mandel_pkg::coord_t ci,
		input mandel_pkg::iters_t max_iters
	);
		mandel_pkg::coord_t x;
		mandel_pkg::coord_t y;
		logic signed [63:0] xw;
		logic signed [63:0] yw;
		logic signed [63:0] xx;
		logic signed [63:0] yy;
		logic signed [63:0] xy;
		logic signed [63:0] mag;
		logic signed [63:0] re;
		int unsigned k;
		bit stop;
		x = '0;
		y = '0;
		k = 0;
		stop = 1'b0;
		while (!stop) begin
			xw = x;
			yw = y;
			xx = xw * xw;
			yy = yw * yw;
			xy = xw * yw;
			mag = xx + yy;
			re = xx - yy;
			k = k + 1;
			// top byte is the integer part of |z|^2
			if (mag[63:56] >= 8'd4 || k >= 32'(max_iters)) begin
				stop = 1'b1;
			end else begin
				x = re[59:28] + cr;
				y = xy[58:27] + ci;
			end
		end
		return k[15:0];
	endfunction

	task automatic check_value(input string name, input longint unsigned got,
			input longint unsigned exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("Mismatch at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		failure_count++;
		$display("Error at %0t ns: %s", $time, what);
	endtask

	task automatic print_summary();
		$display("%0d of %0d results seen, %0d mismatches, %0d other errors",
			results_seen, NUM_TASKS, mismatch_count, failure_count);
	endtask

	initial begin : stimulus
		mandel_pkg::coord_t cr_rand;
		mandel_pkg::coord_t ci_rand;
		mandel_pkg::iters_t m;
		int unsigned largest;
		int unsigned seed_sink;
		seed_sink = $urandom(39628);
		reset = 1'b1;
		snk_data = '0;
		snk_valid = 1'b0;
		src_ready = 1'b0;

		// inside the set, escape at 2.0, and a zero limit
		task_vec[0] = {16'd50, 32'h0000_0000, 32'h0000_0000};
		task_vec[1] = {16'd50, 32'h2000_0000, 32'h0000_0000};
		task_vec[2] = {16'd0, 32'h1000_0000, 32'h0000_0000};
		largest = 50;
		for (int i = 3; i < NUM_TASKS; i++) begin
			cr_rand = $urandom;
			ci_rand = $urandom;
			m = 16'(1 + ($urandom % 64));
			// arithmetic shift maps the full word onto [-2, 2)
			task_vec[i] = {m, cr_rand >>> 2, ci_rand >>> 2};
			if (32'(m) > largest)
				largest = 32'(m);
		end
		watchdog_ns = longint'(NUM_TASKS) * longint'(largest + 10) * CLK_PERIOD;
		tasks_ready = 1'b1;

		check_value("expected_count(c=0, max 50)", expected_count(32'h0, 32'h0, 16'd50), 50);
		check_value("expected_count(c=2, max 50)", expected_count(32'h2000_0000, 32'h0, 16'd50), 2);
		check_value("expected_count(c=1, max 0)", expected_count(32'h1000_0000, 32'h0, 16'd0), 1);

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		@(negedge clk);
		check_value("snk_ready", snk_ready, 1);
		check_value("src_valid", src_valid, 0);

		@(posedge clk);
		#DRIVE_DELAY;
		for (int i = 0; i < NUM_TASKS; i++) begin
			snk_data = task_vec[i];
			snk_valid = 1'b1;
			@(negedge clk);
			while (!snk_ready)
				@(negedge clk);
			@(posedge clk);
			#DRIVE_DELAY;
			snk_valid = 1'b0;
		end

		wait (results_seen == NUM_TASKS);
		repeat (2) @(posedge clk);
		print_summary();
		if (mismatch_count == 0 && failure_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// holds src_ready low for 0 to 10 cycles on each result
	initial begin : source_driver
		int unsigned stall;
		wait (reset === 1'b0);
		forever begin
			@(posedge clk);
			#DRIVE_DELAY;
			if (src_valid && !src_ready) begin
				stall = $urandom % 11;
				repeat (stall) begin
					@(posedge clk);
					#DRIVE_DELAY;
				end
				src_ready = 1'b1;
				@(posedge clk);
				#DRIVE_DELAY;
				src_ready = 1'b0;
			end
		end
	end

	// handshakes sampled mid-cycle, ahead of the edge that completes them
	always @(negedge clk) begin
		if (!reset) begin
			cycle_count++;
			if (snk_valid && snk_ready) begin
				expected_q.push_back(expected_count(
					snk_data[mandel_pkg::CR_LSB +: mandel_pkg::COORD_W],
					snk_data[mandel_pkg::CI_LSB +: mandel_pkg::COORD_W],
					snk_data[mandel_pkg::ITERS_LSB +: mandel_pkg::ITER_W]));
				accept_cycle_q.push_back(cycle_count);
			end
			if (src_valid) begin
				check_value("snk_ready", snk_ready, 0);
				if (!src_valid_prev && accept_cycle_q.size() > 0)
					check_value("latency", cycle_count - accept_cycle_q[0] - 1, expected_q[0]);
				else if (src_valid_prev && !src_ready_prev)
					check_value("src_data (held)", src_data, src_data_prev);
				if (src_ready) begin
					results_seen++;
					if (expected_q.size() == 0) begin
						report_failure("a result was returned with no pending task");
					end else begin
						check_value("src_data", src_data, expected_q.pop_front());
						void'(accept_cycle_q.pop_front());
					end
				end
			end
			src_valid_prev = src_valid;
			src_ready_prev = src_ready;
			src_data_prev = src_data;
		end
	end

	initial begin : watchdog
		wait (tasks_ready);
		#(watchdog_ns);
		report_failure("watchdog expired before all results were consumed");
		print_summary();
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
hw/mandel_pkg.sv
hw/mandel_orbit.sv
hw/mandel_ctrl.sv
hw/mandel_engine.sv
bench/mandel_engine_tb.sv

// File: hw/mandel_ctrl.sv
/* Control for the iteration engine: sink and source handshakes, busy/done state
   and the iteration counter. Drives load and step to the orbit datapath. */

`timescale 1ns/100ps
`default_nettype none

module mandel_ctrl (
	input  logic               clk,
	input  logic               reset,
	input  logic               snk_valid,
	output logic               snk_ready,
	input  mandel_pkg::iters_t max_iters_in,
	input  logic               escaped,
	output logic               load,
	output logic               step,
	output logic               src_valid,
	input  logic               src_ready,
	output mandel_pkg::iters_t src_data
);

	logic busy;
	logic done;

	mandel_pkg::iters_t max_iters;
	mandel_pkg::iters_t cur_iters;

	// one bit wider so the compare cannot wrap at the top of the range
	logic [mandel_pkg::ITER_W:0] count_next;

	logic accept;
	logic keep_going;

	assign snk_ready = ~busy & ~done;
	assign accept    = snk_valid & snk_ready;

	assign load = accept;
	assign step = busy;

	assign count_next = cur_iters + 1'b1;

	// stop on escape or once the next count reaches the limit
	assign keep_going = ~escaped && (count_next < {1'b0, max_iters});

	assign src_valid = done;
	assign src_data  = cur_iters;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else if (accept) begin
			busy <= 1'b1;
		end else if (busy) begin
			busy <= keep_going;
			done <= ~keep_going;
		end else if (done) begin
			// result stays up until the source takes it
			done <= ~src_ready;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			max_iters <= '0;
			cur_iters <= '0;
		end else if (accept) begin
			max_iters <= max_iters_in;
			cur_iters <= '0;
		end else if (busy) begin
			cur_iters <= count_next[mandel_pkg::ITER_W-1:0];
		end
	end

	busy_done_exclusive: assert property (
		@(posedge clk) disable iff (reset)
		!(busy && done)
	) else $error("ctrl: busy and done both set");

	// a stalled result must not move or drop
	result_held: assert property (
		@(posedge clk) disable iff (reset)
		(src_valid && !src_ready) |=> (src_valid && $stable(src_data))
	) else $error("ctrl: result changed under back-pressure");

endmodule

`default_nettype wire

// File: hw/mandel_engine.sv
/* Top level of the Mandelbrot iteration engine. Takes {max_iters, cr, ci} on the
   sink port and returns the iteration count on the source port. */

`timescale 1ns/100ps
`default_nettype none

module mandel_engine (
	input  logic                         clk,
	input  logic                         reset,
	input  logic [mandel_pkg::VEC_W-1:0] snk_data,
	input  logic                         snk_valid,
	output logic                         snk_ready,
	output mandel_pkg::iters_t           src_data,
	output logic                         src_valid,
	input  logic                         src_ready
);

	// fields of the input vector
	mandel_pkg::iters_t max_iters;
	mandel_pkg::coord_t cr;
	mandel_pkg::coord_t ci;

	logic load;
	logic step;
	logic escaped;

	assign max_iters = snk_data[mandel_pkg::ITERS_LSB +: mandel_pkg::ITER_W];
	assign cr        = snk_data[mandel_pkg::CR_LSB +: mandel_pkg::COORD_W];
	assign ci        = snk_data[mandel_pkg::CI_LSB +: mandel_pkg::COORD_W];

	mandel_ctrl ctrl_inst (
		.clk          (clk),
		.reset        (reset),
		.snk_valid    (snk_valid),
		.snk_ready    (snk_ready),
		.max_iters_in (max_iters),
		.escaped      (escaped),
		.load         (load),
		.step         (step),
		.src_valid    (src_valid),
		.src_ready    (src_ready),
		.src_data     (src_data)
	);

	// c is only sampled at load, the sink fields may change afterwards
	mandel_orbit orbit_inst (
		.clk     (clk),
		.reset   (reset),
		.load    (load),
		.step    (step),
		.cr_in   (cr),
		.ci_in   (ci),
		.escaped (escaped)
	);

endmodule

`default_nettype wire

// File: hw/mandel_orbit.sv
/* Orbit datapath: holds c and z, forms x*x, y*y and x*y each cycle and advances
   z on step. Flags escape combinationally from the current z. */

`timescale 1ns/100ps
`default_nettype none

module mandel_orbit (
	input  logic               clk,
	input  logic               reset,
	input  logic               load,
	input  logic               step,
	input  mandel_pkg::coord_t cr_in,
	input  mandel_pkg::coord_t ci_in,
	output logic               escaped
);

	// point c, captured at load
	mandel_pkg::coord_t cr;
	mandel_pkg::coord_t ci;

	// current z = x + iy
	mandel_pkg::coord_t x;
	mandel_pkg::coord_t y;

	// full signed products
	logic signed [mandel_pkg::PROD_W-1:0] xx;
	logic signed [mandel_pkg::PROD_W-1:0] yy;
	logic signed [mandel_pkg::PROD_W-1:0] xy;

	logic signed [mandel_pkg::PROD_W-1:0] mag_sq;
	logic signed [mandel_pkg::PROD_W-1:0] re_sq;

	logic [mandel_pkg::MAG_TOP_W-1:0] mag_top;

	mandel_pkg::coord_t next_x;
	mandel_pkg::coord_t next_y;

	// operands are sign extended to the 64-bit context before multiplying
	assign xx = x * x;
	assign yy = y * y;
	assign xy = x * y;

	assign mag_sq = xx + yy;
	assign re_sq  = xx - yy;

	// product carries 56 fraction bits, so the top byte holds the integer part
	assign mag_top = mag_sq[mandel_pkg::PROD_W-1 -: mandel_pkg::MAG_TOP_W];
	assign escaped = (mag_top >= mandel_pkg::ESCAPE_LIMIT);

	// re(z^2) = xx - yy, realigned to 28 fraction bits
	assign next_x = re_sq[mandel_pkg::FRAC_BITS +: mandel_pkg::COORD_W] + cr;

	// im(z^2) = 2xy, so take the slice one bit lower for the doubling
	assign next_y = xy[mandel_pkg::FRAC_BITS-1 +: mandel_pkg::COORD_W] + ci;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cr <= '0;
			ci <= '0;
		end else if (load) begin
			cr <= cr_in;
			ci <= ci_in;
		end
	end

	// z starts at zero for every new point
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			x <= '0;
			y <= '0;
		end else if (load) begin
			x <= '0;
			y <= '0;
		end else if (step) begin
			x <= next_x;
			y <= next_y;
		end
	end

	// a new task can only arrive while the engine is idle
	load_step_exclusive: assert property (
		@(posedge clk) disable iff (reset)
		!(load && step)
	) else $error("orbit: load and step high in the same cycle");

endmodule

`default_nettype wire

// File: hw/mandel_pkg.sv
/* Fixed-point format, input vector layout and escape constants shared by the
   Mandelbrot iteration engine and its testbench. Referenced by scoped name. */

`default_nettype none

package mandel_pkg;

	// signed coordinate, 4 integer bits above 28 fraction bits
	localparam int INT_BITS  = 4;
	localparam int FRAC_BITS = 28;
	localparam int COORD_W   = INT_BITS + FRAC_BITS;

	// full width of a signed coordinate product
	localparam int PROD_W = 2 * COORD_W;

	// iteration count width, also the result width
	localparam int ITER_W = 16;

	// input vector is {max_iters, cr, ci}
	localparam int VEC_W     = ITER_W + 2 * COORD_W;
	localparam int ITERS_LSB = 2 * COORD_W;
	localparam int CR_LSB    = COORD_W;
	localparam int CI_LSB    = 0;

	// escape test looks only at the top byte of x*x + y*y
	// a value of 4 in that byte means |z|^2 >= 4.0 in the product format
	localparam int MAG_TOP_W = 8;
	localparam logic [MAG_TOP_W-1:0] ESCAPE_LIMIT = 8'd4;

	typedef logic signed [COORD_W-1:0] coord_t;
	typedef logic [ITER_W-1:0] iters_t;

endpackage

`default_nettype wire
